//--- estimator_defines.svh
`ifndef ESTIMATOR_DEFINES_SVH
`define ESTIMATOR_DEFINES_SVH

// Channel count equals the number of control bits per input word
`define NUM_CHANNELS 3

// Internal fixed-point format, sign + INT_BITS + FRAC_BITS
`define FRAC_BITS 10
`define INT_BITS 4

// Offset-binary output word
`define OUT_WIDTH 14

// Strobes accepted before results are meaningful
`define WARMUP_SAMPLES 8

// Cycles from input strobe to output strobe
`define PIPE_DEPTH 5

`endif

//--- fixPkg.sv
`include "estimator_defines.svh"

package fixPkg;

    // Signed internal value, 1.0 is 2**FRAC_BITS
    typedef logic signed [`FRAC_BITS+`INT_BITS:0] fixT;

    // Full product of two internal values
    typedef logic signed [2*(`FRAC_BITS+`INT_BITS+1)-1:0] prodT;

    // Channel sum with headroom for the output scaling
    typedef logic signed [`FRAC_BITS+`INT_BITS+`OUT_WIDTH-1:0] accT;

    typedef logic [`NUM_CHANNELS-1:0] ctrlWordT;
    typedef logic [`OUT_WIDTH-1:0] outWordT;

    typedef struct packed {
        fixT re;
        fixT im;
    } cplxT;

    typedef struct packed {
        logic     valid;
        ctrlWordT ctrl;
    } sampleT;

    typedef enum logic {
        WARMING,
        RUNNING
    } warmStateT;

endpackage

//--- coeffPkg.sv
`include "estimator_defines.svh"

package coeffPkg;
    import fixPkg::*;

    function automatic cplxT cx(input int re, input int im);
        cplxT c;
        c.re = fixT'(re);
        c.im = fixT'(im);
        return c;
    endfunction

    // Values in units of 2**-10, so 1024 is 1.0
    // Row is the channel, column the control bit
    localparam cplxT inCoeff [`NUM_CHANNELS][`NUM_CHANNELS] = '{
        '{cx(96, 16), cx(64, -24), cx(48, 8)},
        '{cx(80, -16), cx(112, 32), cx(56, -8)},
        '{cx(40, 12), cx(72, -20), cx(88, 4)}
    };

    // Poles, all well inside the unit circle
    localparam cplxT recFactor [`NUM_CHANNELS] = '{
        cx(768, 128),
        cx(640, -256),
        cx(896, 64)
    };

    localparam cplxT outWeight [`NUM_CHANNELS] = '{
        cx(768, -256),
        cx(512, 128),
        cx(640, 256)
    };

endpackage

//--- ctrlLut.sv
`timescale 1ns/1ps
`include "estimator_defines.svh"

module ctrlLut
    import fixPkg::*;
(
    input  logic     clkDS,
    input  logic     rst,
    input  logic     strobe,
    input  ctrlWordT ctrlBits,
    input  cplxT     coeffs [`NUM_CHANNELS],
    output cplxT     term,
    output logic     termValid
);

    cplxT sum;

    // Set bit adds its coefficient, clear bit subtracts it
    always_comb begin
        sum = '0;
        for (int b = 0; b < `NUM_CHANNELS; b++) begin
            if (ctrlBits[b]) begin
                sum.re = sum.re + coeffs[b].re;
                sum.im = sum.im + coeffs[b].im;
            end else begin
                sum.re = sum.re - coeffs[b].re;
                sum.im = sum.im - coeffs[b].im;
            end
        end
    end

    always_ff @(posedge clkDS or negedge rst) begin
        if (!rst) begin
            termValid <= 1'b0;
        end else begin
            termValid <= strobe;
        end
    end

    always_ff @(posedge clkDS) begin
        if (strobe) begin
            term <= sum;
        end
    end

endmodule

//--- cplxRecursion.sv
`timescale 1ns/1ps
`include "estimator_defines.svh"

module cplxRecursion
    import fixPkg::*;
(
    input  logic clkDS,
    input  logic rst,
    input  logic stepValid,
    input  cplxT term,
    input  cplxT factor,
    output cplxT state,
    output logic stateValid
);

    prodT prodRr;
    prodT prodIi;
    prodT prodRi;
    prodT prodIr;
    cplxT next;

    // state <= factor * state + term, each product truncated on its own
    always_comb begin
        prodRr = prodT'(factor.re) * prodT'(state.re);
        prodIi = prodT'(factor.im) * prodT'(state.im);
        prodRi = prodT'(factor.re) * prodT'(state.im);
        prodIr = prodT'(factor.im) * prodT'(state.re);
        next.re = fixT'(prodRr >>> `FRAC_BITS) - fixT'(prodIi >>> `FRAC_BITS) + term.re;
        next.im = fixT'(prodRi >>> `FRAC_BITS) + fixT'(prodIr >>> `FRAC_BITS) + term.im;
    end

    // Holds between strobes
    always_ff @(posedge clkDS or negedge rst) begin
        if (!rst) begin
            state <= '0;
            stateValid <= 1'b0;
        end else begin
            stateValid <= stepValid;
            if (stepValid) begin
                state <= next;
            end
        end
    end

endmodule

//--- channelSlice.sv
`timescale 1ns/1ps
`include "estimator_defines.svh"

module channelSlice
    import fixPkg::*;
    import coeffPkg::*;
#(
    parameter int channelIdx = 0
) (
    input  logic   clkDS,
    input  logic   rst,
    input  sampleT sampleIn,
    input  logic   warmIn,
    output fixT    weighted,
    output logic   sliceValid,
    output logic   warmOut
);

    localparam cplxT weight = outWeight[channelIdx];

    cplxT term;
    cplxT state;
    logic termValid;
    logic stateValid;
    logic [2:0] warmPipe;
    prodT weightedRe;

    ctrlLut lut (
        .clkDS    (clkDS),
        .rst      (rst),
        .strobe   (sampleIn.valid),
        .ctrlBits (sampleIn.ctrl),
        .coeffs   (inCoeff[channelIdx]),
        .term     (term),
        .termValid(termValid)
    );

    cplxRecursion recursion (
        .clkDS     (clkDS),
        .rst       (rst),
        .stepValid (termValid),
        .term      (term),
        .factor    (recFactor[channelIdx]),
        .state     (state),
        .stateValid(stateValid)
    );

    // Real part of state * weight
    assign weightedRe = prodT'(state.re) * prodT'(weight.re)
                      - prodT'(state.im) * prodT'(weight.im);

    always_ff @(posedge clkDS) begin
        if (stateValid) begin
            weighted <= fixT'(weightedRe >>> `FRAC_BITS);
        end
    end

    // Warm flag rides along with the three pipeline stages
    always_ff @(posedge clkDS or negedge rst) begin
        if (!rst) begin
            sliceValid <= 1'b0;
            warmPipe <= '0;
        end else begin
            sliceValid <= stateValid;
            warmPipe <= {warmPipe[1:0], warmIn};
        end
    end

    assign warmOut = warmPipe[2];

endmodule

//--- outputStage.sv
`timescale 1ns/1ps
`include "estimator_defines.svh"

module outputStage
    import fixPkg::*;
(
    input  logic    clkDS,
    input  logic    rst,
    input  fixT     parts [`NUM_CHANNELS],
    input  logic    partsValid,
    input  logic    warm,
    output outWordT outWord,
    output logic    outValid
);

    localparam int outShift = `OUT_WIDTH - 1 - `FRAC_BITS;
    localparam accT satMax = accT'((1 <<< (`OUT_WIDTH - 1)) - 1);
    localparam accT satMin = -satMax - accT'(1);

    accT sum;
    accT sumReg;
    accT scaled;
    outWordT clipped;
    logic validD1;
    logic warmD1;

    always_comb begin
        sum = '0;
        for (int c = 0; c < `NUM_CHANNELS; c++) begin
            sum = sum + accT'(parts[c]);
        end
    end

    // Scale to a signed fraction of OUT_WIDTH bits and clamp
    always_comb begin
        scaled = sumReg <<< outShift;
        if (scaled > satMax) begin
            clipped = satMax[`OUT_WIDTH-1:0];
        end else if (scaled < satMin) begin
            clipped = satMin[`OUT_WIDTH-1:0];
        end else begin
            clipped = scaled[`OUT_WIDTH-1:0];
        end
    end

    always_ff @(posedge clkDS or negedge rst) begin
        if (!rst) begin
            validD1 <= 1'b0;
            warmD1 <= 1'b0;
            outValid <= 1'b0;
        end else begin
            validD1 <= partsValid;
            warmD1 <= warm;
            outValid <= validD1 & warmD1;
        end
    end

    always_ff @(posedge clkDS) begin
        if (partsValid) begin
            sumReg <= sum;
        end
        // Offset binary
        if (validD1) begin
            outWord <= {~clipped[`OUT_WIDTH-1], clipped[`OUT_WIDTH-2:0]};
        end
    end

endmodule

//--- warmupCtrl.sv
`timescale 1ns/1ps
`include "estimator_defines.svh"

module warmupCtrl
    import fixPkg::*;
(
    input  logic clkDS,
    input  logic rst,
    input  logic strobe,
    output logic warm
);

    localparam int cntWidth = $clog2(`WARMUP_SAMPLES + 1);

    warmStateT state;
    logic [cntWidth-1:0] count;
    logic lastStrobe;

    assign lastStrobe = strobe && (count == cntWidth'(`WARMUP_SAMPLES - 1));

    always_ff @(posedge clkDS or negedge rst) begin
        if (!rst) begin
            state <= WARMING;
            count <= '0;
        end else begin
            case (state)
                WARMING: begin
                    if (strobe) begin
                        count <= count + 1'b1;
                        if (lastStrobe) begin
                            state <= RUNNING;
                        end
                    end
                end
                default: begin
                    // Stays running until reset
                end
            endcase
        end
    end

    // The completing strobe already counts as warm
    assign warm = (state == RUNNING) || lastStrobe;

endmodule

//--- batchEstimator.sv
`timescale 1ns/1ps
`include "estimator_defines.svh"

module batchEstimator
    import fixPkg::*;
(
    input  logic    clkDS,
    input  logic    rst,
    input  sampleT  sampleIn,
    output outWordT outWord,
    output logic    outValid
);

    logic warm;
    fixT parts [`NUM_CHANNELS];
    logic sliceValid [`NUM_CHANNELS];
    logic sliceWarm [`NUM_CHANNELS];

    warmupCtrl warmup (
        .clkDS (clkDS),
        .rst   (rst),
        .strobe(sampleIn.valid),
        .warm  (warm)
    );

    for (genvar ch = 0; ch < `NUM_CHANNELS; ch++) begin : gChannel
        channelSlice #(
            .channelIdx(ch)
        ) slice (
            .clkDS     (clkDS),
            .rst       (rst),
            .sampleIn  (sampleIn),
            .warmIn    (warm),
            .weighted  (parts[ch]),
            .sliceValid(sliceValid[ch]),
            .warmOut   (sliceWarm[ch])
        );
    end

    // All slices run in lockstep, channel 0 paces the output
    outputStage outStage (
        .clkDS     (clkDS),
        .rst       (rst),
        .parts     (parts),
        .partsValid(sliceValid[0]),
        .warm      (sliceWarm[0]),
        .outWord   (outWord),
        .outValid  (outValid)
    );

endmodule

//--- batchEstimator_asserts.sv
`timescale 1ns/1ps
`include "estimator_defines.svh"

module batchEstimator_asserts
    import fixPkg::*;
(
    input logic   clkDS,
    input logic   rst,
    input sampleT sampleIn,
    input logic   outValid
);

    int failCount = 0;
    int strobeCount;

    // Strobes since reset, stops at the warm-up length
    always_ff @(posedge clkDS or negedge rst) begin
        if (!rst) begin
            strobeCount <= 0;
        end else if (sampleIn.valid && strobeCount < `WARMUP_SAMPLES) begin
            strobeCount <= strobeCount + 1;
        end
    end

    noOutputInReset: assert property (@(posedge clkDS) !rst |-> !outValid)
        else begin
            $error("outValid high while reset is active");
            failCount++;
        end

    outputHasStrobe: assert property (@(posedge clkDS) disable iff (!rst)
        outValid |-> $past(sampleIn.valid, `PIPE_DEPTH))
        else begin
            $error("outValid without a strobe PIPE_DEPTH cycles earlier");
            failCount++;
        end

    outputAfterWarmup: assert property (@(posedge clkDS) disable iff (!rst)
        outValid |-> strobeCount >= `WARMUP_SAMPLES)
        else begin
            $error("outValid before the warm-up strobes were seen");
            failCount++;
        end

endmodule

bind batchEstimator batchEstimator_asserts i_asserts (
    .clkDS   (clkDS),
    .rst     (rst),
    .sampleIn(sampleIn),
    .outValid(outValid)
);

//--- tb_batchEstimator.sv
`timescale 1ns/1ps
`include "estimator_defines.svh"

module tb_batchEstimator
    import fixPkg::*;
    import coeffPkg::*;
();

    localparam int drainLimit = 200;
    localparam int maxCommands = 1000;

    logic clkDS;
    logic rst;
    sampleT sampleIn;
    outWordT outWord;
    logic outValid;

    int cycle = 0;
    int errCount = 0;
    int checkCount = 0;
    int testNum = 0;
    bit timedOut = 1'b0;
    outWordT lastWord;
    bit haveLast = 1'b0;
    outWordT monWord;
    int monCycle;

    // Reference model state, one complex value per channel
    longint stRe [`NUM_CHANNELS];
    longint stIm [`NUM_CHANNELS];
    int warmCount;
    outWordT expWords [$];
    int expCycles [$];

    batchEstimator i_dut (
        .clkDS   (clkDS),
        .rst     (rst),
        .sampleIn(sampleIn),
        .outWord (outWord),
        .outValid(outValid)
    );

    initial clkDS = 1'b0;
    always #50 clkDS = ~clkDS;

    always @(posedge clkDS) cycle <= cycle + 1;

    // Keep only the bits of an internal value, with its sign
    function automatic longint wrapFix(input longint v);
        fixT w;
        w = fixT'(v);
        return longint'(w);
    endfunction

    task automatic modelStep(input ctrlWordT ctrl, output outWordT word);
        longint tRe;
        longint tIm;
        longint fRe;
        longint fIm;
        longint nRe;
        longint nIm;
        longint acc;
        longint scaled;
        acc = 0;
        for (int ch = 0; ch < `NUM_CHANNELS; ch++) begin
            tRe = 0;
            tIm = 0;
            for (int b = 0; b < `NUM_CHANNELS; b++) begin
                if (ctrl[b]) begin
                    tRe = tRe + longint'(inCoeff[ch][b].re);
                    tIm = tIm + longint'(inCoeff[ch][b].im);
                end else begin
                    tRe = tRe - longint'(inCoeff[ch][b].re);
                    tIm = tIm - longint'(inCoeff[ch][b].im);
                end
            end
            fRe = longint'(recFactor[ch].re);
            fIm = longint'(recFactor[ch].im);
            nRe = wrapFix(((fRe * stRe[ch]) >>> `FRAC_BITS)
                        - ((fIm * stIm[ch]) >>> `FRAC_BITS) + tRe);
            nIm = wrapFix(((fRe * stIm[ch]) >>> `FRAC_BITS)
                        + ((fIm * stRe[ch]) >>> `FRAC_BITS) + tIm);
            stRe[ch] = nRe;
            stIm[ch] = nIm;
            acc = acc + wrapFix((stRe[ch] * longint'(outWeight[ch].re)
                               - stIm[ch] * longint'(outWeight[ch].im)) >>> `FRAC_BITS);
        end
        scaled = acc <<< (`OUT_WIDTH - 1 - `FRAC_BITS);
        if (scaled > (longint'(1) <<< (`OUT_WIDTH - 1)) - 1) begin
            scaled = (longint'(1) <<< (`OUT_WIDTH - 1)) - 1;
        end else if (scaled < -(longint'(1) <<< (`OUT_WIDTH - 1))) begin
            scaled = -(longint'(1) <<< (`OUT_WIDTH - 1));
        end
        word = outWordT'(scaled);
        word[`OUT_WIDTH-1] = ~word[`OUT_WIDTH-1];
    endtask

    task automatic driveCycle(input bit strobe, input ctrlWordT ctrl);
        outWordT word;
        @(posedge clkDS);
        #1;
        sampleIn.valid = strobe;
        sampleIn.ctrl = ctrl;
        if (strobe) begin
            modelStep(ctrl, word);
            warmCount++;
            if (warmCount >= `WARMUP_SAMPLES) begin
                expWords.push_back(word);
                expCycles.push_back(cycle + `PIPE_DEPTH);
            end
        end
    endtask

    task automatic driveIdle();
        driveCycle(1'b0, '0);
    endtask

    task automatic applyReset();
        @(posedge clkDS);
        #1;
        rst = 1'b0;
        sampleIn = '0;
        for (int ch = 0; ch < `NUM_CHANNELS; ch++) begin
            stRe[ch] = 0;
            stIm[ch] = 0;
        end
        warmCount = 0;
        expWords.delete();
        expCycles.delete();
        haveLast = 1'b0;
        repeat (10) @(posedge clkDS);
        #1;
        rst = 1'b1;
    endtask

    task automatic drainOutputs(output bit ok);
        int waited;
        waited = 0;
        while (expWords.size() > 0 && waited < drainLimit) begin
            driveIdle();
            waited++;
        end
        ok = (expWords.size() == 0);
        if (!ok) begin
            $display("Timeout: %0d expected outputs never arrived", expWords.size());
        end
    endtask

    // Outputs are stable at the falling edge
    always @(negedge clkDS) begin
        if (rst && outValid) begin
            checkCount++;
            assert (expWords.size() > 0) else begin
                $display("outValid at cycle %0d without a matching strobe", cycle);
                errCount++;
            end
            if (expWords.size() > 0) begin
                monWord = expWords.pop_front();
                monCycle = expCycles.pop_front();
                checkCount += 2;
                assert (outWord == monWord) else begin
                    $display("Error: outWord is %h, expected %h", outWord, monWord);
                    errCount++;
                end
                assert (cycle == monCycle) else begin
                    $display("outValid came at cycle %0d instead of cycle %0d",
                             cycle, monCycle);
                    errCount++;
                end
            end
            lastWord = outWord;
            haveLast = 1'b1;
        end
    end

    initial begin
        int fd;
        int code;
        int argA;
        int argB;
        int argC;
        int gapLen;
        int errBase;
        int chkBase;
        logic [7:0] cmd;
        logic [8*128-1:0] lineBuf;
        bit finished;
        bit ok;
        rst = 1'b0;
        sampleIn = '0;
        errBase = 0;
        chkBase = 0;
        void'($urandom(32'h05b074c0));
        applyReset();

        fd = $fopen("estimator_stim.txt", "r");
        checkCount++;
        assert (fd != 0) else begin
            $display("Could not open estimator_stim.txt");
            errCount++;
        end
        finished = (fd == 0);
        for (int n = 0; n < maxCommands && !finished; n++) begin
            code = $fscanf(fd, "%s", cmd);
            if (code != 1) begin
                finished = 1'b1;
            end else if (cmd == "#") begin
                code = $fgets(lineBuf, fd);
            end else if (cmd == "S") begin
                code = $fscanf(fd, "%h %d", argA, argB);
                repeat (argB) driveCycle(1'b1, ctrlWordT'(argA));
            end else if (cmd == "R") begin
                code = $fscanf(fd, "%h %d %d", argA, argB, argC);
                repeat (argB) begin
                    gapLen = $urandom % (argC + 1);
                    repeat (gapLen) driveIdle();
                    driveCycle(1'b1, ctrlWordT'(argA));
                end
            end else if (cmd == "G") begin
                code = $fscanf(fd, "%d", argA);
                repeat (argA) driveIdle();
            end else if (cmd == "X") begin
                applyReset();
            end else if (cmd == "E") begin
                code = $fscanf(fd, "%h", argA);
                drainOutputs(ok);
                checkCount++;
                assert (haveLast) else begin
                    $display("No output seen before the expected word");
                    errCount++;
                end
                if (haveLast) begin
                    assert (lastWord == outWordT'(argA)) else begin
                        $display("Error: outWord is %h, expected %h",
                                 lastWord, outWordT'(argA));
                        errCount++;
                    end
                end
                timedOut = timedOut || !ok;
                finished = !ok;
            end else if (cmd == "T") begin
                drainOutputs(ok);
                repeat (`PIPE_DEPTH + 1) driveIdle();
                testNum++;
                $display("test %0d finished: %0d checks, %0d errors",
                         testNum, checkCount - chkBase, errCount - errBase);
                chkBase = checkCount;
                errBase = errCount;
                timedOut = timedOut || !ok;
                finished = !ok;
            end else begin
                $display("Unknown command in estimator_stim.txt");
                errCount++;
                finished = 1'b1;
            end
        end
        if (fd != 0) begin
            $fclose(fd);
        end

        errCount = errCount + i_dut.i_asserts.failCount;
        $display("%0d tests, %0d checks, %0d errors", testNum, checkCount, errCount);
        if (errCount == 0 && !timedOut) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

//--- estimator_stim.txt
# S ctrl n: n strobes back to back | R ctrl n max: n strobes after random gaps of 0..max
# G n: n idle cycles | X: reset | E word: last output must equal word | T: end of test
# test 1 warm-up after power-on reset
S 5 7
G 6
S 2 1
G 3
S 6 2
T
# test 2 back-to-back assorted control words
S 0 1
S 7 1
S 3 1
S 4 1
S 1 2
S 6 1
S 2 3
S 5 1
T
# test 3 random gaps between strobes
R 3 12 5
R 6 12 5
R 1 8 3
T
# test 4 saturation at both ends
S 7 60
E 3fff
S 0 60
E 0000
T
# test 5 reset in mid-run restarts the warm-up
S 5 4
X
S 7 7
G 6
S 1 6
T

//--- build.f
+incdir+.
fixPkg.sv
coeffPkg.sv
ctrlLut.sv
cplxRecursion.sv
channelSlice.sv
outputStage.sv
warmupCtrl.sv
batchEstimator.sv
batchEstimator_asserts.sv
tb_batchEstimator.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the estimator testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal -f build.f \
    --top-module tb_batchEstimator -o tbSim \
    && ./obj_dir/tbSim > sim.log 2>&1 \
    || echo "Build or simulation ended with an error status"
cat sim.log 2>/dev/null
grep -qx "PASS: all tests" sim.log && echo "Run passed" || { echo "Run failed"; exit 1; }
